//--- memArbPkg.sv
package memArbPkg;

    // controller opcodes, encoding kept from the older arbiter
    typedef enum logic [1:0] {
        opIdle  = 2'b00,
        opRead  = 2'b01,
        opWrite = 2'b11
    } memOpT;

    // request FSM states
    typedef enum logic [3:0] {
        stInit        = 4'b0000,
        stIdle        = 4'b0001,
        stInstrRd     = 4'b0010,
        stInstrRdDone = 4'b0011,
        stDataRd      = 4'b0100,
        stDataRdDone  = 4'b0101,
        stDataWr      = 4'b0110,
        stDataWrDone  = 4'b0111,
        stAccelRd     = 4'b1000,
        stAccelRdDone = 4'b1001,
        stAccelWr     = 4'b1010,
        stAccelWrDone = 4'b1011
    } arbStateT;

    // who owns the controller port right now
    typedef enum logic [1:0] {
        clNone  = 2'b00,
        clInstr = 2'b01,
        clData  = 2'b10,
        clAccel = 2'b11
    } clientT;

    // arbiter -> controller
    typedef struct packed {
        memOpT        op;
        logic [31:0]  addr;
        logic [511:0] wrData;
    } memReqT;

    // controller -> arbiter, both strobes are one-cycle pulses
    typedef struct packed {
        logic         txDone;
        logic         rdValid;
        logic [511:0] rdData;
    } memRspT;

    // block handed back to a client
    typedef struct packed {
        logic         valid;
        logic [511:0] blk;
    } blkRspT;

    // signal table load port
    typedef struct packed {
        logic        en;
        logic [17:0] sigNum;
        logic [17:0] baseBlk;
    } sigTblWrT;

    localparam logic [31:0] blkBytes    = 32'd64;        // one cache line
    localparam logic [31:0] blkAddrMask = 32'hFFFF_FFC0; // drops byte-in-block bits

endpackage

//--- sigAddrTable.sv
`timescale 1ns/1ns

module sigAddrTable #(
    parameter int          sigEntries    = 64,
    parameter logic [31:0] sigRegionBase = 32'h1000_0000
) (
    input  logic                accelWrBlkDone,
    input  logic                accelRdBlkDone,
    input  memArbPkg::sigTblWrT tblWr,
    input  logic [17:0]         sigNum,
    output logic [31:0]         sigBaseAddr
);

    localparam int idxW = (sigEntries > 1) ? $clog2(sigEntries) : 1;

    logic [17:0]     baseTbl [sigEntries]; // base block per signal
    logic [idxW-1:0] wrIdx;
    logic [idxW-1:0] rdIdx;

    assign wrIdx = tblWr.sigNum[idxW-1:0];
    assign rdIdx = sigNum[idxW-1:0]; // upper sigNum bits ignored

    always_ff @(posedge accelWrBlkDone, posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            for (int i = 0; i < sigEntries; i++) begin
                baseTbl[i] <= '0;
            end
        end else if (tblWr.en) begin
            baseTbl[wrIdx] <= tblWr.baseBlk;
        end
    end

    // block number to byte address inside the signal region
    assign sigBaseAddr = sigRegionBase + ({14'b0, baseTbl[rdIdx]} * memArbPkg::blkBytes);

    // loader must stay inside the table, otherwise an entry gets aliased
    tblWrInRange: assert property (
        @(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        tblWr.en |-> (32'(tblWr.sigNum) < sigEntries)
    ) else $error("sigAddrTable write to sigNum %0d past %0d entries",
                  tblWr.sigNum, sigEntries);

endmodule

//--- sigBlkCounter.sv
`timescale 1ns/1ns

module sigBlkCounter #(
    parameter int   sigBlks = 8,
    localparam int  offW    = (sigBlks > 1) ? $clog2(sigBlks) : 1
) (
    input  logic            accelWrBlkDone,
    input  logic            accelRdBlkDone,
    input  logic            clear,     // burst start
    input  logic            advance,   // one block finished
    output logic [offW-1:0] blkOffset,
    output logic            lastBlk
);

    // position of the current block inside the burst
    always_ff @(posedge accelWrBlkDone, posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            blkOffset <= '0;
        end else if (clear) begin
            blkOffset <= '0;
        end else if (advance) begin
            if (lastBlk) begin
                blkOffset <= '0; // wrap, ready for the next burst
            end else begin
                blkOffset <= blkOffset + offW'(1);
            end
        end
    end

    assign lastBlk = (blkOffset == offW'(sigBlks - 1));

    // once the final block completes nothing may advance until a new burst is started
    noAdvancePastLast: assert property (
        @(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        (advance && lastBlk) |=> (!advance until clear)
    ) else $error("sigBlkCounter advanced beyond block %0d", sigBlks - 1);

endmodule

//--- memBusSteer.sv
`timescale 1ns/1ns

module memBusSteer #(
    parameter int   sigBlks = 8,
    localparam int  offW    = (sigBlks > 1) ? $clog2(sigBlks) : 1
) (
    input  memArbPkg::clientT client,
    input  logic [31:0]       instrAddr,
    input  logic [31:0]       dataAddr,
    input  logic [511:0]      dataBlk2Mem,
    input  logic [511:0]      accelBlk2Mem,
    input  logic [31:0]       sigBaseAddr,
    input  logic [offW-1:0]   blkOffset,
    input  memArbPkg::memRspT memRsp,
    output logic [31:0]       memAddr,
    output logic [511:0]      memWrData,
    output memArbPkg::blkRspT instrRsp,
    output memArbPkg::blkRspT dataRsp,
    output memArbPkg::blkRspT accelRsp
);

    logic [31:0] instrAddrAln;
    logic [31:0] dataAddrAln;
    logic [31:0] accelAddr;

    assign instrAddrAln = instrAddr & memArbPkg::blkAddrMask;
    assign dataAddrAln  = dataAddr & memArbPkg::blkAddrMask;

    // walk consecutive blocks from the signal's base
    assign accelAddr = (sigBaseAddr + (32'(blkOffset) * memArbPkg::blkBytes))
                     & memArbPkg::blkAddrMask;

    always_comb begin
        memAddr   = '0;
        memWrData = '0;
        unique case (client)
            memArbPkg::clInstr: memAddr = instrAddrAln; // reads only
            memArbPkg::clData: begin
                memAddr   = dataAddrAln;
                memWrData = dataBlk2Mem;  // used on evict
            end
            memArbPkg::clAccel: begin
                memAddr   = accelAddr;
                memWrData = accelBlk2Mem;
            end
            default: ; // clNone, port idle
        endcase
    end

    // read data goes only to whoever is being served
    always_comb begin
        instrRsp = '0;
        dataRsp  = '0;
        accelRsp = '0;
        unique case (client)
            memArbPkg::clInstr: instrRsp = '{valid: memRsp.rdValid, blk: memRsp.rdData};
            memArbPkg::clData:  dataRsp  = '{valid: memRsp.rdValid, blk: memRsp.rdData};
            memArbPkg::clAccel: accelRsp = '{valid: memRsp.rdValid, blk: memRsp.rdData};
            default: ;
        endcase
    end

endmodule

//--- memArbFsm.sv
`timescale 1ns/1ns

module memArbFsm (
    input  logic              accelWrBlkDone,
    input  logic              accelRdBlkDone,
    input  logic              instrReq,
    input  logic              dataRdReq,
    input  logic              dataEvictReq,
    input  logic              accelRdReq,
    input  logic              accelWrReq,
    input  logic              txDone,   // controller took the request
    input  logic              rdValid,  // read block on the bus
    input  logic              lastBlk,
    output memArbPkg::memOpT  op,
    output memArbPkg::clientT client,
    output logic              cntClear,
    output logic              cntAdvance,
    output logic              dataEvictAck,
    output logic              accelRdAck,
    output logic              accelWrAck,
    output logic              accelXferDone
);

    memArbPkg::arbStateT state, nextState;

    logic accelAny;
    logic dataAny;
    logic blkAck;

    assign accelAny = accelRdReq | accelWrReq;
    assign dataAny  = dataRdReq | dataEvictReq;

    always_comb begin
        nextState = state;
        unique case (state)
            memArbPkg::stInit: nextState = memArbPkg::stIdle;
            memArbPkg::stIdle: begin
                // fixed priority: accel, data, instr
                if (accelAny) begin
                    nextState = accelRdReq ? memArbPkg::stAccelRd : memArbPkg::stAccelWr;
                end else if (dataAny) begin
                    nextState = dataEvictReq ? memArbPkg::stDataWr : memArbPkg::stDataRd;
                end else if (instrReq) begin
                    nextState = memArbPkg::stInstrRd;
                end
            end
            memArbPkg::stInstrRd:     if (txDone) nextState = memArbPkg::stInstrRdDone;
            memArbPkg::stInstrRdDone: if (rdValid) nextState = memArbPkg::stIdle;
            memArbPkg::stDataRd:      if (txDone) nextState = memArbPkg::stDataRdDone;
            memArbPkg::stDataRdDone:  if (rdValid) nextState = memArbPkg::stIdle;
            memArbPkg::stDataWr:      if (txDone) nextState = memArbPkg::stDataWrDone;
            memArbPkg::stDataWrDone:  nextState = memArbPkg::stIdle; // single ack cycle
            memArbPkg::stAccelRd:     if (txDone) nextState = memArbPkg::stAccelRdDone;
            memArbPkg::stAccelRdDone: begin
                if (rdValid) begin
                    nextState = lastBlk ? memArbPkg::stIdle : memArbPkg::stAccelRd;
                end
            end
            memArbPkg::stAccelWr:     if (txDone) nextState = memArbPkg::stAccelWrDone;
            memArbPkg::stAccelWrDone: begin
                nextState = lastBlk ? memArbPkg::stIdle : memArbPkg::stAccelWr;
            end
            default: nextState = memArbPkg::stIdle;
        endcase
    end

    always_ff @(posedge accelWrBlkDone, posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            state <= memArbPkg::stInit;
        end else begin
            state <= nextState;
        end
    end

    // op and owner follow the state alone, steady while waiting on the controller
    always_comb begin
        op     = memArbPkg::opIdle;
        client = memArbPkg::clNone;
        unique case (state)
            memArbPkg::stInstrRd: begin
                op     = memArbPkg::opRead;
                client = memArbPkg::clInstr;
            end
            memArbPkg::stInstrRdDone: client = memArbPkg::clInstr;
            memArbPkg::stDataRd: begin
                op     = memArbPkg::opRead;
                client = memArbPkg::clData;
            end
            memArbPkg::stDataWr: begin
                op     = memArbPkg::opWrite;
                client = memArbPkg::clData;
            end
            memArbPkg::stDataRdDone, memArbPkg::stDataWrDone: client = memArbPkg::clData;
            memArbPkg::stAccelRd: begin
                op     = memArbPkg::opRead;
                client = memArbPkg::clAccel;
            end
            memArbPkg::stAccelWr: begin
                op     = memArbPkg::opWrite;
                client = memArbPkg::clAccel;
            end
            memArbPkg::stAccelRdDone, memArbPkg::stAccelWrDone: client = memArbPkg::clAccel;
            default: ; // init, idle
        endcase
    end

    // per-block strobes
    assign dataEvictAck = (state == memArbPkg::stDataWrDone);
    assign accelRdAck   = (state == memArbPkg::stAccelRdDone) && rdValid;
    assign accelWrAck   = (state == memArbPkg::stAccelWrDone);
    assign blkAck       = accelRdAck | accelWrAck;

    assign accelXferDone = blkAck && lastBlk; // with the final block's ack
    assign cntClear      = (state == memArbPkg::stIdle) && accelAny; // burst about to start
    assign cntAdvance    = blkAck;

    // accepted request leaves the port idle in the following cycle
    opIdleOutsideReq: assert property (
        @(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        ((op != memArbPkg::opIdle) && txDone) |=> (op == memArbPkg::opIdle)
    ) else $error("memArbFsm op %s still driven after txDone", op.name());

    // one ack per accepted transfer
    acksOneHot: assert property (
        @(posedge accelWrBlkDone) disable iff (accelRdBlkDone)
        (dataEvictAck || accelRdAck || accelWrAck)
            |=> (!(dataEvictAck || accelRdAck || accelWrAck) until txDone)
    ) else $error("memArbFsm acknowledged more than once for one transfer");

endmodule

//--- memArbTop.sv
`timescale 1ns/1ns

module memArbTop #(
    parameter int          sigEntries    = 64,
    parameter int          sigBlks       = 8,
    parameter logic [31:0] sigRegionBase = 32'h1000_0000
) (
    input  logic                accelWrBlkDone,
    input  logic                accelRdBlkDone,
    // instruction cache
    input  logic                instrReq,
    input  logic [31:0]         instrAddr,
    output memArbPkg::blkRspT   instrRsp,
    // data cache
    input  logic                dataRdReq,
    input  logic                dataEvictReq,
    input  logic [31:0]         dataAddr,
    input  logic [511:0]        dataBlk2Mem,
    output memArbPkg::blkRspT   dataRsp,
    output logic                dataEvictAck,
    // accelerator buffer
    input  logic                accelRdReq,
    input  logic                accelWrReq,
    input  logic [17:0]         sigNum,
    input  logic [511:0]        accelBlk2Mem,
    output memArbPkg::blkRspT   accelRsp,
    output logic                accelRdAck,
    output logic                accelWrAck,
    output logic                accelXferDone,
    // signal table load
    input  memArbPkg::sigTblWrT tblWr,
    // memory controller
    output memArbPkg::memReqT   memReq,
    input  memArbPkg::memRspT   memRsp
);

    localparam int offW = (sigBlks > 1) ? $clog2(sigBlks) : 1;

    memArbPkg::memOpT  op;
    memArbPkg::clientT client;
    logic [31:0]       sigBaseAddr;
    logic [31:0]       memAddr;
    logic [511:0]      memWrData;
    logic [offW-1:0]   blkOffset;
    logic              lastBlk;
    logic              cntClear;
    logic              cntAdvance;

    sigAddrTable #(
        .sigEntries    (sigEntries),
        .sigRegionBase (sigRegionBase)
    ) sigAddrTable_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .tblWr          (tblWr),
        .sigNum         (sigNum),
        .sigBaseAddr    (sigBaseAddr)
    );

    sigBlkCounter #(
        .sigBlks (sigBlks)
    ) sigBlkCounter_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .clear          (cntClear),
        .advance        (cntAdvance),
        .blkOffset      (blkOffset),
        .lastBlk        (lastBlk)
    );

    memBusSteer #(
        .sigBlks (sigBlks)
    ) memBusSteer_i (
        .client       (client),
        .instrAddr    (instrAddr),
        .dataAddr     (dataAddr),
        .dataBlk2Mem  (dataBlk2Mem),
        .accelBlk2Mem (accelBlk2Mem),
        .sigBaseAddr  (sigBaseAddr),
        .blkOffset    (blkOffset),
        .memRsp       (memRsp),
        .memAddr      (memAddr),
        .memWrData    (memWrData),
        .instrRsp     (instrRsp),
        .dataRsp      (dataRsp),
        .accelRsp     (accelRsp)
    );

    memArbFsm memArbFsm_i (
        .accelWrBlkDone (accelWrBlkDone),
        .accelRdBlkDone (accelRdBlkDone),
        .instrReq       (instrReq),
        .dataRdReq      (dataRdReq),
        .dataEvictReq   (dataEvictReq),
        .accelRdReq     (accelRdReq),
        .accelWrReq     (accelWrReq),
        .txDone         (memRsp.txDone),
        .rdValid        (memRsp.rdValid),
        .lastBlk        (lastBlk),
        .op             (op),
        .client         (client),
        .cntClear       (cntClear),
        .cntAdvance     (cntAdvance),
        .dataEvictAck   (dataEvictAck),
        .accelRdAck     (accelRdAck),
        .accelWrAck     (accelWrAck),
        .accelXferDone  (accelXferDone)
    );

    // controller request bundle
    assign memReq = '{op: op, addr: memAddr, wrData: memWrData};

endmodule

//--- memArbTb.sv
`timescale 1ns/1ns

module memArbTb;

    localparam int          sigBlks    = 8;
    localparam int          numTests   = 6;
    localparam int          cycleLimit = numTests * (sigBlks + 2) * 10;
    localparam logic [31:0] regionBase = 32'h1000_0000;
    localparam logic [31:0] blkSize    = 32'd64;

    // request kinds in the stimulus table
    localparam int kindInstr   = 0;
    localparam int kindDataRd  = 1;
    localparam int kindEvict   = 2;
    localparam int kindAccelRd = 3;
    localparam int kindAccelWr = 4;
    localparam int kindRace    = 5; // instr, data and accel raised together

    typedef struct packed {
        int           kind;
        logic [31:0]  addr;    // instr or data address
        logic [31:0]  addr2;   // data address in the priority test
        logic [17:0]  sigNum;
        logic [511:0] wrBlk;
        logic [31:0]  expAddr; // first address expected at the controller
    } stimRowT;

    logic                accelWrBlkDone; // clock
    logic                accelRdBlkDone; // reset
    logic                instrReq;
    logic [31:0]         instrAddr;
    memArbPkg::blkRspT   instrRsp;
    logic                dataRdReq;
    logic                dataEvictReq;
    logic [31:0]         dataAddr;
    logic [511:0]        dataBlk2Mem;
    memArbPkg::blkRspT   dataRsp;
    logic                dataEvictAck;
    logic                accelRdReq;
    logic                accelWrReq;
    logic [17:0]         sigNum;
    logic [511:0]        accelBlk2Mem;
    memArbPkg::blkRspT   accelRsp;
    logic                accelRdAck;
    logic                accelWrAck;
    logic                accelXferDone;
    memArbPkg::sigTblWrT tblWr;
    memArbPkg::memReqT   memReq;
    memArbPkg::memRspT   memRsp;

    stimRowT          stimTbl [numTests];
    string            kindNames [6] = '{"instr read", "data read", "evict", "accel read",
                                        "accel write", "priority"};
    logic [511:0]     memStore [logic [31:0]]; // controller's write store
    logic [31:0]      reqAddrQ [$];             // every request the controller saw
    memArbPkg::memOpT reqOpQ [$];
    logic [511:0]     accelBlkQ [$];
    logic [511:0]     instrBlk;
    logic [511:0]     dataBlk;
    int instrValidCnt, dataValidCnt, accelValidCnt;
    int evictAckCnt, rdAckCnt, wrAckCnt, xferDoneCnt;
    int errCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    logic [31:0] lcgState = 32'd96863;

    // controller model
    int               mdlPhase = 0; // 0 free, 1 waiting to accept, 2 read pending
    int               mdlCnt;
    logic [31:0]      mdlAddr;
    memArbPkg::memOpT mdlOp;

    memArbTop dut_i (.*);

    always #10 accelWrBlkDone = ~accelWrBlkDone;

    always @(posedge accelWrBlkDone) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, run still busy after %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {16'b0, lcgState[31:16]};
    endfunction

    always begin
        @(posedge accelWrBlkDone);
        #2;
        memRsp.txDone  = 1'b0; // strobes last one cycle
        memRsp.rdValid = 1'b0;
        if (accelRdBlkDone) begin
            mdlPhase = 0;
        end else begin
            if (mdlPhase == 0 && memReq.op != memArbPkg::opIdle) begin
                mdlAddr = memReq.addr;
                mdlOp   = memReq.op;
                reqAddrQ.push_back(memReq.addr);
                reqOpQ.push_back(memReq.op);
                mdlCnt   = lcgNext() % 4; // accept after 1..4 cycles
                mdlPhase = 1;
            end
            if (mdlPhase == 1) begin
                if (mdlCnt == 0) begin
                    memRsp.txDone = 1'b1;
                    if (mdlOp == memArbPkg::opWrite) begin
                        memStore[mdlAddr] = memReq.wrData;
                        mdlPhase = 0;
                    end else begin
                        mdlCnt   = lcgNext() % 3 + 1; // data 1..3 cycles later
                        mdlPhase = 2;
                    end
                end else begin
                    mdlCnt--;
                end
            end else if (mdlPhase == 2) begin
                mdlCnt--;
                if (mdlCnt == 0) begin
                    memRsp.rdValid = 1'b1;
                    memRsp.rdData  = {16{mdlAddr}};
                    mdlPhase = 0;
                end
            end
        end
    end

    // pulse counters, sampled mid-cycle
    always @(negedge accelWrBlkDone) begin
        if (instrRsp.valid) begin
            instrValidCnt++;
            instrBlk = instrRsp.blk;
        end
        if (dataRsp.valid) begin
            dataValidCnt++;
            dataBlk = dataRsp.blk;
        end
        if (accelRsp.valid) begin
            accelValidCnt++;
            accelBlkQ.push_back(accelRsp.blk);
        end
        if (dataEvictAck) evictAckCnt++;
        if (accelRdAck) rdAckCnt++;
        if (accelWrAck) wrAckCnt++;
        if (accelXferDone) begin
            xferDoneCnt++;
            if (rdAckCnt + wrAckCnt != sigBlks) begin
                $display("accelXferDone at %0t ns came before the last block ack", $time);
                errCount++;
            end
        end
    end

    task automatic reportMismatch(input string sig, input logic [511:0] got,
                                  input logic [511:0] exp);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, sig, got, exp);
        errCount++;
    endtask

    task automatic clearCounts();
        instrValidCnt = 0;
        dataValidCnt  = 0;
        accelValidCnt = 0;
        evictAckCnt   = 0;
        rdAckCnt      = 0;
        wrAckCnt      = 0;
        xferDoneCnt   = 0;
        reqAddrQ.delete();
        reqOpQ.delete();
        accelBlkQ.delete();
    endtask

    // wait for the completion pulse of one kind, then step to the next drive point
    task automatic waitFor(input int kind);
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            @(negedge accelWrBlkDone);
            case (kind)
                kindInstr:  hit = instrRsp.valid;
                kindDataRd: hit = dataRsp.valid;
                kindEvict:  hit = dataEvictAck;
                default:    hit = accelXferDone;
            endcase
        end
        @(posedge accelWrBlkDone);
        #2;
    endtask

    task automatic loadEntry(input logic [17:0] num, input logic [17:0] base);
        tblWr = '{1'b1, num, base};
        @(posedge accelWrBlkDone);
        #2;
        tblWr.en = 1'b0;
    endtask

    task automatic runTest(input int idx);
        stimRowT     row;
        int          errBefore;
        int          nReq;
        logic [31:0] blkAddr;
        row       = stimTbl[idx];
        errBefore = errCount;
        clearCounts();
        case (row.kind)
            kindInstr: begin
                instrAddr = row.addr;
                instrReq  = 1'b1;
            end
            kindDataRd: begin
                dataAddr  = row.addr;
                dataRdReq = 1'b1;
            end
            kindEvict: begin
                dataAddr     = row.addr;
                dataBlk2Mem  = row.wrBlk;
                dataEvictReq = 1'b1;
            end
            kindAccelRd: begin
                sigNum     = row.sigNum;
                accelRdReq = 1'b1;
            end
            kindAccelWr: begin
                sigNum       = row.sigNum;
                accelBlk2Mem = row.wrBlk;
                accelWrReq   = 1'b1;
            end
            default: begin
                instrAddr  = row.addr;
                dataAddr   = row.addr2;
                sigNum     = row.sigNum;
                instrReq   = 1'b1;
                dataRdReq  = 1'b1;
                accelRdReq = 1'b1;
            end
        endcase
        if (row.kind == kindRace) begin
            waitFor(kindAccelRd);
            accelRdReq = 1'b0;
            waitFor(kindDataRd);
            dataRdReq = 1'b0;
            waitFor(kindInstr);
            instrReq = 1'b0;
            nReq = sigBlks + 2;
        end else begin
            waitFor(row.kind);
            instrReq     = 1'b0;
            dataRdReq    = 1'b0;
            dataEvictReq = 1'b0;
            accelRdReq   = 1'b0;
            accelWrReq   = 1'b0;
            nReq = (row.kind >= kindAccelRd) ? sigBlks : 1;
        end

        if (reqAddrQ.size() != nReq) begin
            $display("test %0d expected %0d controller requests but saw %0d",
                     idx, nReq, reqAddrQ.size());
            errCount++;
        end else if (row.kind <= kindEvict) begin
            if (reqAddrQ[0] != row.expAddr) reportMismatch("memReq.addr", reqAddrQ[0], row.expAddr);
            if (row.kind == kindInstr) begin
                if (instrValidCnt != 1) reportMismatch("instrRsp.valid count", instrValidCnt, 1);
                if (instrBlk != {16{row.expAddr}}) reportMismatch("instrRsp.blk", instrBlk,
                                                                  {16{row.expAddr}});
            end else if (row.kind == kindDataRd) begin
                if (dataValidCnt != 1) reportMismatch("dataRsp.valid count", dataValidCnt, 1);
                if (instrValidCnt != 0) reportMismatch("instrRsp.valid count", instrValidCnt, 0);
                if (accelValidCnt != 0) reportMismatch("accelRsp.valid count", accelValidCnt, 0);
                if (dataBlk != {16{row.expAddr}}) reportMismatch("dataRsp.blk", dataBlk,
                                                                 {16{row.expAddr}});
            end else begin
                if (reqOpQ[0] != memArbPkg::opWrite) reportMismatch("memReq.op", reqOpQ[0],
                                                                    memArbPkg::opWrite);
                if (evictAckCnt != 1) reportMismatch("dataEvictAck count", evictAckCnt, 1);
                if (!memStore.exists(row.expAddr)) begin
                    $display("eviction left nothing stored at %h", row.expAddr);
                    errCount++;
                end else if (memStore[row.expAddr] != row.wrBlk) begin
                    reportMismatch("stored evict block", memStore[row.expAddr], row.wrBlk);
                end
            end
        end else begin
            // burst walks consecutive blocks from the table entry
            for (int i = 0; i < sigBlks; i++) begin
                blkAddr = row.expAddr + i * blkSize;
                if (reqAddrQ[i] != blkAddr) reportMismatch("memReq.addr", reqAddrQ[i], blkAddr);
                if (row.kind == kindAccelWr) begin
                    if (!memStore.exists(blkAddr) || memStore[blkAddr] != row.wrBlk) begin
                        $display("accel write block %0d missing or wrong at %h", i, blkAddr);
                        errCount++;
                    end
                end else if (accelBlkQ.size() == sigBlks && accelBlkQ[i] != {16{blkAddr}}) begin
                    reportMismatch("accelRsp.blk", accelBlkQ[i], {16{blkAddr}});
                end
            end
            if (xferDoneCnt != 1) reportMismatch("accelXferDone count", xferDoneCnt, 1);
            if (row.kind == kindAccelWr) begin
                if (wrAckCnt != sigBlks) reportMismatch("accelWrAck count", wrAckCnt, sigBlks);
            end else begin
                if (rdAckCnt != sigBlks) reportMismatch("accelRdAck count", rdAckCnt, sigBlks);
                if (accelValidCnt != sigBlks) reportMismatch("accelRsp.valid count",
                                                             accelValidCnt, sigBlks);
            end
            if (row.kind == kindRace) begin
                blkAddr = row.addr2 & ~32'h3F;
                if (reqAddrQ[sigBlks] != blkAddr) reportMismatch("memReq.addr after accel",
                                                                 reqAddrQ[sigBlks], blkAddr);
                blkAddr = row.addr & ~32'h3F;
                if (reqAddrQ[sigBlks + 1] != blkAddr) reportMismatch("memReq.addr after data",
                                                                     reqAddrQ[sigBlks + 1],
                                                                     blkAddr);
            end
        end

        if (errCount == errBefore) passCount++;
        else failCount++;
        $display("test %0d %s: %s", idx, kindNames[row.kind],
                 (errCount == errBefore) ? "ok" : "failed");
    endtask

    initial begin
        int errBefore;
        accelWrBlkDone = 1'b0;
        accelRdBlkDone = 1'b1;
        instrReq       = 1'b0;
        instrAddr      = '0;
        dataRdReq      = 1'b0;
        dataEvictReq   = 1'b0;
        dataAddr       = '0;
        dataBlk2Mem    = '0;
        accelRdReq     = 1'b0;
        accelWrReq     = 1'b0;
        sigNum         = '0;
        accelBlk2Mem   = '0;
        tblWr          = '0;
        memRsp         = '0;
        clearCounts();

        // expected addresses: region base plus base block times 64
        stimTbl[0] = '{kindInstr, 32'h0000_1234, 32'h0, 18'd0, '0, 32'h0000_1200};
        stimTbl[1] = '{kindEvict, 32'h0000_2079, 32'h0, 18'd0, {8{64'hA5A5_0000_1111_2222}},
                       32'h0000_2040};
        stimTbl[2] = '{kindDataRd, 32'h0000_30FF, 32'h0, 18'd0, '0, 32'h0000_30C0};
        stimTbl[3] = '{kindAccelRd, 32'h0, 32'h0, 18'd9, '0, regionBase + 32'h0008_0000};
        stimTbl[4] = '{kindAccelWr, 32'h0, 32'h0, 18'd63, {16{32'hC0DE_0063}},
                       regionBase + 32'h0002_AF00};
        stimTbl[5] = '{kindRace, 32'h0000_4010, 32'h0000_5020, 18'd5, '0,
                       regionBase + 32'h0000_4000};

        repeat (8) @(posedge accelWrBlkDone);
        #2;
        accelRdBlkDone = 1'b0;

        // quiet port and outputs with nothing requested
        errBefore = errCount;
        repeat (4) begin
            @(negedge accelWrBlkDone);
            if (memReq.op != memArbPkg::opIdle) reportMismatch("memReq.op", memReq.op,
                                                               memArbPkg::opIdle);
            if (instrRsp.valid || dataRsp.valid || accelRsp.valid) begin
                $display("a client valid went high after reset with no request");
                errCount++;
            end
            if (dataEvictAck || accelRdAck || accelWrAck || accelXferDone) begin
                $display("an acknowledge went high after reset with no request");
                errCount++;
            end
        end
        if (errCount == errBefore) passCount++;
        else failCount++;
        $display("reset idle check: %s", (errCount == errBefore) ? "ok" : "failed");

        @(posedge accelWrBlkDone);
        #2;
        loadEntry(18'd5, 18'h00100);
        loadEntry(18'd9, 18'h02000);
        loadEntry(18'd63, 18'h00ABC);

        for (int i = 0; i < numTests; i++) begin
            runTest(i);
        end

        $display("%0d checks run, %0d passed, %0d failed, %0d errors",
                 passCount + failCount, passCount, failCount, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
memArbPkg.sv
sigAddrTable.sv
sigBlkCounter.sv
memBusSteer.sv
memArbFsm.sv
memArbTop.sv
memArbTb.sv

//--- Bender.yml
package:
  name: memarb

sources:
  - memArbPkg.sv
  - sigAddrTable.sv
  - sigBlkCounter.sv
  - memBusSteer.sv
  - memArbFsm.sv
  - memArbTop.sv
  - target: simulation
    files:
      - memArbTb.sv
